/* common/sparse_pkg.sv */
/*
 * shared sizes, sample and threshold types, output word union
 * and the empty buffer marker
 */
package sparse_pkg;

  localparam int CHANNELS     = 2;   // input channels, one bank each
  localparam int SAMPLE_WIDTH = 16;
  localparam int INDEX_WIDTH  = 12;  // saved-sample index in a stamp
  localparam int CLOCK_WIDTH  = 20;  // cycle count in a stamp
  localparam int WORD_WIDTH   = 32;  // output stream word
  localparam int DATA_DEPTH   = 16;  // entries per sample bank
  localparam int STAMP_DEPTH  = 4;   // entries per timestamp bank
  localparam int BANK_WIDTH   = $clog2(CHANNELS);
  localparam int PAD_WIDTH    = WORD_WIDTH - 1 - SAMPLE_WIDTH;

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  // per-channel hysteresis limits
  typedef struct packed {
    sample_t low;
    sample_t high;
  } thr_t;

  // timestamp record: where in the channel's data it sits, and when
  typedef struct packed {
    logic [INDEX_WIDTH-1:0] index;
    logic [CLOCK_WIDTH-1:0] clock;
  } stamp_view_t;

  // sample record, channel on the msb
  typedef struct packed {
    logic                 channel;
    logic [PAD_WIDTH-1:0] zero;  // always cleared
    sample_t              sample;
  } sample_view_t;

  // one output word, read as a stamp or as a sample depending on stream position
  typedef union packed {
    stamp_view_t  stamp;
    sample_view_t data;
  } out_word_t;

  localparam out_word_t EMPTY_MARK = '1; // sent by a buffer with nothing captured

endpackage

/* common/capture_if.sv */
/*
 * discriminator results to both buffers, per-channel one-cycle strobes
 */
`timescale 1ns/100ps

interface capture_if import sparse_pkg::*; ();

  logic [CHANNELS-1:0] sample_valid;         // strobe, no back-pressure
  out_word_t           sample_word [CHANNELS]; // sample view
  logic [CHANNELS-1:0] stamp_valid;          // low-to-high transition
  out_word_t           stamp_word [CHANNELS];  // stamp view

  modport source (
    output sample_valid, sample_word, stamp_valid, stamp_word
  );

  modport sample_sink (input sample_valid, sample_word);

  modport stamp_sink (input stamp_valid, stamp_word);

endinterface

/* common/stream_if.sv */
/*
 * valid/ready/last stream of output words
 */
`timescale 1ns/100ps

interface stream_if import sparse_pkg::*; ();

  out_word_t data;   // held steady until accepted
  logic      valid;
  logic      last;   // final word of a readout
  logic      ready;

  // buffer side
  modport source (output data, valid, last, input ready);

  // sequencer side
  modport sink (input data, valid, last, output ready);

endinterface

/* hw/sample_discriminator.sv */
/*
 * per-channel hysteresis discriminator with sample index and cycle counters,
 * formats sample and timestamp records for the buffers
 */
`timescale 1ns/100ps

module sample_discriminator import sparse_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    in_valid,
  input  sample_t in_samples [CHANNELS],
  input  logic    thr_valid,
  input  sample_t thr_low [CHANNELS],
  input  sample_t thr_high [CHANNELS],
  input  logic    restart,   // new capture, clears flags and counters
  capture_if.source cap
);

  thr_t                   thr [CHANNELS];
  logic [CHANNELS-1:0]    is_high;
  logic [CHANNELS-1:0]    next_high;
  logic [INDEX_WIDTH-1:0] count [CHANNELS];  // samples saved so far
  logic [CLOCK_WIDTH-1:0] clock;             // cycles since restart

  // hysteresis, held between the two limits
  always_comb begin
    for (int c = 0; c < CHANNELS; c++) begin
      if (in_samples[c] > thr[c].high) next_high[c] = 1'b1;
      else if (in_samples[c] < thr[c].low) next_high[c] = 1'b0;
      else next_high[c] = is_high[c];
    end
  end

  always_ff @(posedge clk) begin
    if (thr_valid) begin
      for (int c = 0; c < CHANNELS; c++) begin
        thr[c].low  <= thr_low[c];
        thr[c].high <= thr_high[c];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset || restart) begin
      // sample in a restart cycle is dropped
      is_high          <= '0;
      clock            <= '0;
      cap.sample_valid <= '0;
      cap.stamp_valid  <= '0;
      for (int c = 0; c < CHANNELS; c++) count[c] <= '0;
    end else begin
      clock            <= clock + 1'b1;
      cap.sample_valid <= in_valid ? next_high : '0;
      cap.stamp_valid  <= in_valid ? (next_high & ~is_high) : '0; // rising edge only
      if (in_valid) begin
        is_high <= next_high;
        for (int c = 0; c < CHANNELS; c++) begin
          if (next_high[c]) count[c] <= count[c] + 1'b1;
        end
      end
    end
  end

  // record payload, qualified by the strobes above
  always_ff @(posedge clk) begin
    for (int c = 0; c < CHANNELS; c++) begin
      cap.sample_word[c].data.channel <= 1'(c);
      cap.sample_word[c].data.zero    <= '0;
      cap.sample_word[c].data.sample  <= in_samples[c];
      cap.stamp_word[c].stamp.index   <= count[c];  // count before this sample
      cap.stamp_word[c].stamp.clock   <= clock;
    end
  end

endmodule

/* sample_buffer/sample_buffer.sv */
/*
 * banked capture memory, one bank per channel, with idle/capture/readout FSM
 * and a valid/ready readout stream
 */
`timescale 1ns/100ps

module sample_buffer import sparse_pkg::*; #(
  parameter int DEPTH = DATA_DEPTH  // entries per bank
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [CHANNELS-1:0] wr_valid,
  input  out_word_t           wr_word [CHANNELS],
  input  logic                start,
  input  logic                stop,
  input  logic                stop_other,  // other buffer filled up
  output logic                full,
  output logic                busy,
  stream_if.source            rd
);

  localparam int ADDR_W = $clog2(DEPTH);
  localparam int CNT_W  = $clog2(DEPTH + 1);  // must hold DEPTH itself

  typedef enum logic [1:0] {IDLE, CAPTURE, READOUT} state_t;

  state_t                state;
  out_word_t             mem [CHANNELS][DEPTH];
  logic [CNT_W-1:0]      count [CHANNELS];
  logic [BANK_WIDTH-1:0] rd_bank;
  logic [BANK_WIDTH-1:0] first_bank;
  logic [BANK_WIDTH-1:0] last_bank;
  logic [BANK_WIDTH-1:0] next_bank;    // next non-empty bank after rd_bank
  logic [ADDR_W-1:0]     rd_ptr;
  logic                  all_empty;
  logic                  capture_end;
  logic                  write_ok;
  logic                  bank_end;
  logic                  xfer;

  // scan from the top so the lowest matching bank wins
  always_comb begin
    full       = 1'b0;
    all_empty  = 1'b1;
    first_bank = '0;
    last_bank  = '0;
    next_bank  = '0;
    for (int b = CHANNELS - 1; b >= 0; b--) begin
      if (count[b] == CNT_W'(DEPTH)) full = 1'b1;
      if (count[b] != '0) begin
        if (all_empty) last_bank = BANK_WIDTH'(b);  // first hit is the highest
        all_empty  = 1'b0;
        first_bank = BANK_WIDTH'(b);
        if (b > int'(rd_bank)) next_bank = BANK_WIDTH'(b);
      end
    end
    full = full & (state == CAPTURE);
  end

  assign capture_end = (state == CAPTURE) && (stop || stop_other || full);
  assign write_ok    = (state == CAPTURE) && !capture_end;  // ending cycle writes nothing
  assign bank_end    = (CNT_W'(rd_ptr) + CNT_W'(1)) == count[rd_bank];

  assign rd.valid = (state == READOUT);
  assign rd.data  = all_empty ? EMPTY_MARK : mem[rd_bank][rd_ptr];
  assign rd.last  = rd.valid && (all_empty || (bank_end && rd_bank == last_bank));
  assign xfer     = rd.valid && rd.ready;
  assign busy     = (state != IDLE);

  always_ff @(posedge clk) begin
    for (int c = 0; c < CHANNELS; c++) begin
      if (write_ok && wr_valid[c] && count[c] != CNT_W'(DEPTH))
        mem[c][ADDR_W'(count[c])] <= wr_word[c];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= IDLE;
      rd_bank <= '0;
      rd_ptr  <= '0;
      for (int c = 0; c < CHANNELS; c++) count[c] <= '0;
    end else begin
      unique case (state)
        IDLE: if (start) begin
          state <= CAPTURE;
          for (int c = 0; c < CHANNELS; c++) count[c] <= '0;
        end
        CAPTURE: begin
          if (capture_end) begin
            state   <= READOUT;
            rd_bank <= first_bank;  // empty banks are skipped
            rd_ptr  <= '0;
          end else begin
            for (int c = 0; c < CHANNELS; c++) begin
              if (wr_valid[c] && count[c] != CNT_W'(DEPTH)) count[c] <= count[c] + 1'b1;
            end
          end
        end
        READOUT: if (xfer) begin
          if (rd.last) begin
            state <= IDLE;
          end else if (bank_end) begin
            rd_bank <= next_bank;
            rd_ptr  <= '0;
          end else begin
            rd_ptr <= rd_ptr + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

/* hw/readout_sequencer.sv */
/*
 * output mux of the two buffer streams, all timestamps then all samples
 */
`timescale 1ns/100ps

module readout_sequencer import sparse_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  stream_if.sink    stamps,
  stream_if.sink    samples,
  output out_word_t out_data,
  output logic      out_valid,
  output logic      out_last,
  input  logic      out_ready
);

  typedef enum logic {SEL_STAMPS, SEL_SAMPLES} sel_t;

  sel_t sel;

  // advance on the transfer of each stream's last word
  always_ff @(posedge clk) begin
    if (reset) begin
      sel <= SEL_STAMPS;
    end else begin
      unique case (sel)
        SEL_STAMPS:
          if (stamps.valid && stamps.ready && stamps.last) sel <= SEL_SAMPLES;
        SEL_SAMPLES:
          if (samples.valid && samples.ready && samples.last) sel <= SEL_STAMPS;
        default: sel <= SEL_STAMPS;
      endcase
    end
  end

  always_comb begin
    if (sel == SEL_SAMPLES) begin
      out_data  = samples.data;
      out_valid = samples.valid;
      out_last  = samples.last;
    end else begin
      out_data  = stamps.data;
      out_valid = stamps.valid;
      out_last  = 1'b0;           // stamp last stays internal
    end
  end

  // unselected stream sees no ready and holds its word
  assign stamps.ready  = (sel == SEL_STAMPS) && out_ready;
  assign samples.ready = (sel == SEL_SAMPLES) && out_ready;

endmodule

/* hw/sparse_sample_buffer.sv */
/*
 * top level: discriminator, data and timestamp buffers, readout sequencer
 */
`timescale 1ns/100ps

module sparse_sample_buffer import sparse_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      in_valid,
  input  sample_t   in_samples [CHANNELS],
  input  logic      thr_valid,
  input  sample_t   thr_low [CHANNELS],
  input  sample_t   thr_high [CHANNELS],
  input  logic      start,      // one-cycle pulse
  input  logic      stop,       // one-cycle pulse
  input  logic      out_ready,
  output out_word_t out_data,
  output logic      out_valid,
  output logic      out_last,
  output logic      busy
);

  logic start_ok;  // start accepted only with both buffers idle
  logic data_full, stamp_full;
  logic data_busy, stamp_busy;

  capture_if cap ();
  stream_if  data_rd ();
  stream_if  stamp_rd ();

  assign busy     = data_busy | stamp_busy;
  assign start_ok = start & ~busy;

  sample_discriminator disc (
    .clk, .reset, .in_valid, .in_samples, .thr_valid, .thr_low, .thr_high,
    .restart (start_ok),  // fresh indices and flags per capture
    .cap     (cap)
  );

  // a full bank in either buffer ends capture in both
  sample_buffer #(.DEPTH(DATA_DEPTH)) data_buffer (
    .clk, .reset,
    .wr_valid (cap.sample_valid),
    .wr_word  (cap.sample_word),
    .start    (start_ok),
    .stop,
    .stop_other (stamp_full),
    .full     (data_full),
    .busy     (data_busy),
    .rd       (data_rd)
  );

  sample_buffer #(.DEPTH(STAMP_DEPTH)) stamp_buffer (
    .clk, .reset,
    .wr_valid (cap.stamp_valid),
    .wr_word  (cap.stamp_word),
    .start    (start_ok),
    .stop,
    .stop_other (data_full),
    .full     (stamp_full),
    .busy     (stamp_busy),
    .rd       (stamp_rd)
  );

  readout_sequencer seq (
    .clk, .reset,
    .stamps  (stamp_rd),
    .samples (data_rd),
    .out_data, .out_valid, .out_last, .out_ready
  );

endmodule

/* bench/sparse_chk.sv */
/*
 * output stream and busy assertions, bound to the top level
 */
`timescale 1ns/100ps

module sparse_chk import sparse_pkg::*; (
  input logic      clk,
  input logic      reset,
  input logic      start,
  input out_word_t out_data,
  input logic      out_valid,
  input logic      out_ready,
  input logic      out_last,
  input logic      busy
);

  logic final_xfer;

  assign final_xfer = out_valid && out_ready && out_last;

  // nothing offered straight out of reset
  a_reset_idle: assert property (@(posedge clk) reset |=> !out_valid)
    else $error("out_valid high after reset");

  a_hold: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> $stable(out_data) && out_valid)
    else $error("out_data changed while stalled");

  a_last_valid: assert property (@(posedge clk) disable iff (reset) out_last |-> out_valid)
    else $error("out_last without out_valid");

  a_busy_start: assert property (@(posedge clk) disable iff (reset) start && !busy |=> busy)
    else $error("busy did not rise on start");

  a_busy_hold: assert property (@(posedge clk) disable iff (reset) busy && !final_xfer |=> busy)
    else $error("busy fell before the last word");

endmodule

bind sparse_sample_buffer sparse_chk chk (
  .clk, .reset, .start, .out_data, .out_valid, .out_ready, .out_last, .busy
);

/* bench/tb_sparse_sample_buffer.sv */
/*
 * testbench for the sparse sample capture top level: clock, reset, stimulus table,
 * queue-based reference model, compare tasks and watchdog
 */
`timescale 1ns/100ps

module tb_sparse_sample_buffer import sparse_pkg::*; ();

  typedef struct {
    sample_t low, high;
    int      n;          // samples per channel
    int      mode;       // 0 ramp, 1 alternating ch1, 2 random, 3 all low, 4 all high
    bit      by_fill;    // capture must end on a full bank
    int      ready_mode; // 0 always, 1 random, 2 alternating
  } row_t;

  localparam int ROWS = 7;

  logic      clk = 1'b0, reset = 1'b1, in_valid = 1'b0, thr_valid = 1'b0;
  logic      start = 1'b0, stop = 1'b0, out_ready = 1'b0;
  sample_t   in_samples [CHANNELS] = '{default: '0};
  sample_t   thr_low [CHANNELS] = '{default: '0};
  sample_t   thr_high [CHANNELS] = '{default: '0};
  out_word_t out_data;
  logic      out_valid, out_last, busy;

  row_t      rows [ROWS];
  sample_t   smp [CHANNELS][64];
  out_word_t exp_word[$], got_word[$];
  logic      exp_last[$], got_last[$];
  int        n_stamp_words;            // leading words read in the stamp view
  int        ready_mode = 0, last_count = 0, word_errors = 0, last_errors = 0;
  int        count_errors = 0;
  integer    seed = 32'hc0d4;

  sparse_sample_buffer UUT (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    case (ready_mode)
      1: out_ready <= $random(seed) & 1;
      2: out_ready <= ~out_ready;
      default: out_ready <= 1'b1;
    endcase
  end

  // stable mid-cycle, after the edge's assignments settle
  always @(negedge clk) begin
    if (out_valid && out_ready) begin
      got_word.push_back(out_data);
      got_last.push_back(out_last);
      if (out_last) last_count++;
    end
  end

  task automatic check_word(input out_word_t got, input out_word_t exp, input bit stamp_view);
    if (got !== exp) begin
      word_errors++;
      if (stamp_view)
        $display("ERROR %0t out_data stamp index/clock got %0d/%0d expected %0d/%0d (%h %h)",
                 $time, got.stamp.index, got.stamp.clock, exp.stamp.index, exp.stamp.clock,
                 got, exp);
      else
        $display("ERROR %0t out_data sample ch/value got %0d/%0d expected %0d/%0d (%h %h)",
                 $time, got.data.channel, got.data.sample, exp.data.channel, exp.data.sample,
                 got, exp);
    end
  endtask

  task automatic check_last(input logic got, input logic exp);
    if (got !== exp) begin
      last_errors++;
      $display("ERROR %0t out_last got %b expected %b", $time, got, exp);
    end
  endtask

  // hysteresis and buffer rules, full bank ends both buffers one cycle later
  task automatic predict(input row_t r);
    out_word_t dbank [CHANNELS][$];
    out_word_t sbank [CHANNELS][$];
    bit        flag [CHANNELS];
    int        cnt [CHANNELS];
    bit        nxt, stopped;
    out_word_t w;
    exp_word.delete();
    exp_last.delete();
    flag = '{default: 0};
    cnt = '{default: 0};
    stopped = 0;
    for (int i = 0; i < r.n && !stopped; i++) begin
      for (int c = 0; c < CHANNELS; c++) begin
        nxt = (smp[c][i] > r.high) ? 1'b1 : (smp[c][i] < r.low) ? 1'b0 : flag[c];
        if (nxt) begin
          w.data = '{channel: 1'(c), zero: '0, sample: smp[c][i]};
          if (dbank[c].size() < DATA_DEPTH) dbank[c].push_back(w);
          w.stamp = '{index: INDEX_WIDTH'(cnt[c]), clock: CLOCK_WIDTH'(i)};
          if (!flag[c] && sbank[c].size() < STAMP_DEPTH) sbank[c].push_back(w);
          cnt[c]++;
        end
        flag[c] = nxt;
      end
      for (int c = 0; c < CHANNELS; c++)
        if (dbank[c].size() == DATA_DEPTH || sbank[c].size() == STAMP_DEPTH) stopped = 1;
    end
    for (int c = 0; c < CHANNELS; c++)
      for (int k = 0; k < sbank[c].size(); k++) exp_word.push_back(sbank[c][k]);
    if (exp_word.size() == 0) exp_word.push_back(EMPTY_MARK);
    n_stamp_words = exp_word.size();
    for (int c = 0; c < CHANNELS; c++)
      for (int k = 0; k < dbank[c].size(); k++) exp_word.push_back(dbank[c][k]);
    if (exp_word.size() == n_stamp_words) exp_word.push_back(EMPTY_MARK);
    foreach (exp_word[k]) exp_last.push_back(k == exp_word.size() - 1);
  endtask

  task automatic run_row(input int idx, input row_t r);
    int ramp;
    for (int i = 0; i < r.n; i++) begin
      ramp = (i <= r.n / 2) ? i : r.n - i;
      case (r.mode)
        0: begin
          smp[0][i] = sample_t'(ramp * 100);
          smp[1][i] = sample_t'(ramp * 100 - 150);
        end
        1: begin
          smp[0][i] = -16'sd1000;
          smp[1][i] = i[0] ? 16'sd1000 : -16'sd1000;
        end
        2: begin
          smp[0][i] = sample_t'($random(seed));
          smp[1][i] = sample_t'($random(seed));
        end
        3: begin
          smp[0][i] = -16'sd2000;
          smp[1][i] = -16'sd2000;
        end
        default: begin
          smp[0][i] = 16'sd1000;
          smp[1][i] = 16'sd1000;
        end
      endcase
    end
    predict(r);
    got_word.delete();
    got_last.delete();
    ready_mode = r.ready_mode;
    @(posedge clk);
    thr_valid <= 1'b1;
    thr_low   <= '{default: r.low};
    thr_high  <= '{default: r.high};
    @(posedge clk);
    thr_valid <= 1'b0;
    start     <= 1'b1;
    for (int i = 0; i < r.n; i++) begin
      @(posedge clk);
      start      <= 1'b0;
      in_valid   <= 1'b1;
      in_samples <= '{smp[0][i], smp[1][i]};
    end
    @(posedge clk);
    in_valid <= 1'b0;
    @(posedge clk);  // last strobe lands before the stop
    if (!r.by_fill) begin
      stop <= 1'b1;
      @(posedge clk);
      stop <= 1'b0;
    end
    while (last_count <= idx) @(posedge clk);
    @(negedge clk);
    if (got_word.size() != exp_word.size()) begin
      count_errors++;
      $display("row %0d: received %0d words but expected %0d", idx, got_word.size(),
               exp_word.size());
    end
    for (int k = 0; k < got_word.size() && k < exp_word.size(); k++) begin
      check_word(got_word[k], exp_word[k], k < n_stamp_words);
      check_last(got_last[k], exp_last[k]);
    end
  endtask

  initial begin
    rows[0] = '{200, 500, 20, 0, 0, 0};
    rows[1] = '{200, 500, 20, 0, 0, 1};
    rows[2] = '{0, 500, 16, 1, 1, 2};     // channel 1 fills its stamp bank
    rows[3] = '{200, 500, 10, 3, 0, 1};   // nothing above threshold
    rows[4] = '{-8000, 8000, 30, 2, 0, 1};
    rows[5] = '{0, 500, 5, 4, 0, 0};
    rows[6] = '{0, 500, 5, 4, 0, 2};      // ends high, flags must clear on restart
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    repeat (2) @(posedge clk);
    for (int r = 0; r < ROWS; r++) run_row(r, rows[r]);
    $display("word errors %0d, last errors %0d, count errors %0d",
             word_errors, last_errors, count_errors);
    if (word_errors + last_errors + count_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // samples plus readout and setup per row, four times over
  initial begin
    int limit;
    #1;
    limit = 20;
    foreach (rows[r]) limit += rows[r].n + 2 * CHANNELS * (DATA_DEPTH + STAMP_DEPTH) + 16;
    #(limit * 4 * 20);
    $display("watchdog expired before all readouts finished");
    $display("tests failed");
    $finish;
  end

endmodule

/* src.f */
common/sparse_pkg.sv
common/capture_if.sv
common/stream_if.sv
hw/sample_discriminator.sv
sample_buffer/sample_buffer.sv
hw/readout_sequencer.sv
hw/sparse_sample_buffer.sv
bench/sparse_chk.sv
bench/tb_sparse_sample_buffer.sv

/* run.sh */
#!/bin/sh
# build and run with Verilator, pass is decided from the simulation log
verilator --binary --timing --assert -Wno-fatal --top-module tb_sparse_sample_buffer \
  -f src.f -o sim_tb > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
